/* common/game_pkg.sv */
// shared screen, raster timing, ship geometry, color and FSM definitions for the ship display
`default_nettype none

package game_pkg;

  // --------------------------------------------------------------------------
  // raster timing for 1024x768
  // --------------------------------------------------------------------------
  localparam logic [10:0] h_active = 11'd1024;
  localparam logic [10:0] h_front  = 11'd24;
  localparam logic [10:0] h_sync   = 11'd136;
  localparam logic [10:0] h_back   = 11'd160;
  localparam logic [10:0] h_total  = h_active + h_front + h_sync + h_back;

  localparam logic [10:0] v_active = 11'd768;
  localparam logic [10:0] v_front  = 11'd3;
  localparam logic [10:0] v_sync   = 11'd6;
  localparam logic [10:0] v_back   = 11'd29;
  localparam logic [10:0] v_total  = v_active + v_front + v_sync + v_back;

  // --------------------------------------------------------------------------
  // ship geometry and playfield
  // --------------------------------------------------------------------------
  localparam logic [10:0] rect_width  = 11'd48;
  localparam logic [10:0] rect_height = 11'd64;

  // left edge of the playfield, also the smallest ship x
  localparam logic [10:0] play_x_min  = 11'd80;
  // first column right of the playfield
  localparam logic [10:0] play_x_edge = 11'd944;
  localparam logic [10:0] play_x_max  = play_x_edge - rect_width;

  localparam logic [10:0] reset_xpos = 11'd85;
  localparam logic [10:0] ship_ypos  = 11'd680;

  // --------------------------------------------------------------------------
  // timing defaults, in pclk cycles
  // --------------------------------------------------------------------------
  localparam logic [20:0] step_period_default = 21'd30000;
  localparam logic [15:0] debounce_default    = 16'd1000;

  // --------------------------------------------------------------------------
  // 12-bit rgb colors
  // --------------------------------------------------------------------------
  localparam logic [11:0] color_border = 12'h444;
  localparam logic [11:0] color_field  = 12'h135;
  localparam logic [11:0] color_ship   = 12'hfd2;
  localparam logic [11:0] color_black  = 12'h000;

  // ship controller states
  typedef enum logic [1:0] {
    idle       = 2'b00,
    move_left  = 2'b01,
    move_right = 2'b10
  } move_state_t;

endpackage

`default_nettype wire

/* hdl/key_sync.sv */
// synchronizes and debounces the raw left and right key levels before the ship controller
`timescale 1ns/100ps
`default_nettype none

module key_sync #(
  parameter logic [15:0] debounce_cycles = game_pkg::debounce_default
) (
  input  wire pclk,
  input  wire rst,
  input  wire left_raw,
  input  wire right_raw,
  output wire left,
  output wire right
);

  wire [1:0] raw;
  wire [1:0] keys;

  // bit 0 is left, bit 1 is right
  assign raw = {right_raw, left_raw};

  genvar k;
  generate
    for (k = 0; k < 2; k++) begin : g_key
      logic        sync_a;
      logic        sync_b;
      logic        key_q;
      logic [15:0] stable_cnt;

      always_ff @(posedge pclk) begin
        if (rst) begin
          sync_a     <= 1'b0;
          sync_b     <= 1'b0;
          key_q      <= 1'b0;
          stable_cnt <= 16'd0;
        end else begin
          // two-flop synchronizer
          sync_a <= raw[k];
          sync_b <= sync_a;
          // count cycles the synchronized level differs from the accepted one
          if (sync_b == key_q) begin
            stable_cnt <= 16'd0;
          end else if (stable_cnt == debounce_cycles) begin
            key_q      <= sync_b;
            stable_cnt <= 16'd0;
          end else begin
            stable_cnt <= stable_cnt + 16'd1;
          end
        end
      end

      assign keys[k] = key_q;
    end
  endgenerate

  assign left  = keys[0];
  assign right = keys[1];

endmodule

`default_nettype wire

/* ship/position_rect_ctl.sv */
// ship x-position FSM that steps one pixel per step period while a key is held
`timescale 1ns/100ps
`default_nettype none

module position_rect_ctl #(
  parameter logic [20:0] step_period = game_pkg::step_period_default
) (
  input  wire         pclk,
  input  wire         rst,
  input  wire         left,
  input  wire         right,
  output logic [10:0] xpos_out
);

  game_pkg::move_state_t state;
  game_pkg::move_state_t state_nxt;
  logic [10:0] xpos_nxt;
  logic [20:0] step_cnt;
  logic [20:0] step_cnt_nxt;

  // --------------------------------------------------------------------------
  // state and position registers
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk) begin
    if (rst) begin
      state    <= game_pkg::idle;
      xpos_out <= game_pkg::reset_xpos;
      step_cnt <= 21'd0;
    end else begin
      state    <= state_nxt;
      xpos_out <= xpos_nxt;
      step_cnt <= step_cnt_nxt;
    end
  end

  // --------------------------------------------------------------------------
  // next state, left has priority from idle
  // --------------------------------------------------------------------------
  always_comb begin
    case (state)
      game_pkg::idle: begin
        if (left) begin
          state_nxt = game_pkg::move_left;
        end else if (right) begin
          state_nxt = game_pkg::move_right;
        end else begin
          state_nxt = game_pkg::idle;
        end
      end
      game_pkg::move_left:  state_nxt = left ? game_pkg::move_left : game_pkg::idle;
      game_pkg::move_right: state_nxt = right ? game_pkg::move_right : game_pkg::idle;
      default:              state_nxt = game_pkg::idle;
    endcase
  end

  // --------------------------------------------------------------------------
  // step counter and clamped position update
  // --------------------------------------------------------------------------
  always_comb begin
    // idle keeps a partial count for the next press
    step_cnt_nxt = step_cnt;
    xpos_nxt     = xpos_out;
    case (state)
      game_pkg::move_left: begin
        if (step_cnt == step_period) begin
          step_cnt_nxt = 21'd0;
          if (xpos_out > game_pkg::play_x_min) begin
            xpos_nxt = xpos_out - 11'd1;
          end else begin
            xpos_nxt = game_pkg::play_x_min;
          end
        end else begin
          step_cnt_nxt = step_cnt + 21'd1;
        end
      end
      game_pkg::move_right: begin
        if (step_cnt == step_period) begin
          step_cnt_nxt = 21'd0;
          if (xpos_out < game_pkg::play_x_max) begin
            xpos_nxt = xpos_out + 11'd1;
          end else begin
            xpos_nxt = game_pkg::play_x_max;
          end
        end else begin
          step_cnt_nxt = step_cnt + 21'd1;
        end
      end
      default: begin
        step_cnt_nxt = step_cnt;
        xpos_nxt     = xpos_out;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/vga_timing.sv */
// free-running 1024x768 raster generator with registered counters, sync pulses and blank flag
`timescale 1ns/100ps
`default_nettype none

module vga_timing (
  input  wire         pclk,
  input  wire         rst,
  output logic [10:0] hcount,
  output logic [10:0] vcount,
  output logic        hsync,
  output logic        vsync,
  output logic        blank
);

  logic        h_wrap;
  logic [10:0] hcount_nxt;
  logic [10:0] vcount_nxt;
  logic        hsync_nxt;
  logic        vsync_nxt;
  logic        blank_nxt;

  // --------------------------------------------------------------------------
  // next counter values
  // --------------------------------------------------------------------------
  assign h_wrap = (hcount == game_pkg::h_total - 11'd1);

  always_comb begin
    if (h_wrap) begin
      hcount_nxt = 11'd0;
      if (vcount == game_pkg::v_total - 11'd1) begin
        vcount_nxt = 11'd0;
      end else begin
        vcount_nxt = vcount + 11'd1;
      end
    end else begin
      hcount_nxt = hcount + 11'd1;
      vcount_nxt = vcount;
    end
  end

  // --------------------------------------------------------------------------
  // sync and blank decoded from the next counts
  // --------------------------------------------------------------------------
  // sync pulses are active low
  assign hsync_nxt = !((hcount_nxt >= game_pkg::h_active + game_pkg::h_front) &&
                       (hcount_nxt <  game_pkg::h_active + game_pkg::h_front +
                                      game_pkg::h_sync));

  assign vsync_nxt = !((vcount_nxt >= game_pkg::v_active + game_pkg::v_front) &&
                       (vcount_nxt <  game_pkg::v_active + game_pkg::v_front +
                                      game_pkg::v_sync));

  assign blank_nxt = (hcount_nxt >= game_pkg::h_active) ||
                     (vcount_nxt >= game_pkg::v_active);

  // counters and decoded flags move together
  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount <= 11'd0;
      vcount <= 11'd0;
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      blank  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= hsync_nxt;
      vsync  <= vsync_nxt;
      blank  <= blank_nxt;
    end
  end

endmodule

`default_nettype wire

/* hdl/draw_background.sv */
// first raster pipeline stage, paints blanking black, the side borders and the playfield
`timescale 1ns/100ps
`default_nettype none

module draw_background (
  input  wire         pclk,
  input  wire         rst,
  input  wire  [10:0] hcount_in,
  input  wire  [10:0] vcount_in,
  input  wire         hsync_in,
  input  wire         vsync_in,
  input  wire         blank_in,
  output logic [10:0] hcount_out,
  output logic [10:0] vcount_out,
  output logic        hsync_out,
  output logic        vsync_out,
  output logic        blank_out,
  output logic [11:0] rgb_out
);

  logic [11:0] rgb_nxt;

  always_comb begin
    if (blank_in) begin
      rgb_nxt = game_pkg::color_black;
    end else if ((hcount_in < game_pkg::play_x_min) || (hcount_in >= game_pkg::play_x_edge)) begin
      rgb_nxt = game_pkg::color_border;
    end else begin
      rgb_nxt = game_pkg::color_field;
    end
  end

  // pixel coordinates are payload
  always_ff @(posedge pclk) begin
    hcount_out <= hcount_in;
    vcount_out <= vcount_in;
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync_out <= 1'b1;
      vsync_out <= 1'b1;
      blank_out <= 1'b1;
      rgb_out   <= game_pkg::color_black;
    end else begin
      hsync_out <= hsync_in;
      vsync_out <= vsync_in;
      blank_out <= blank_in;
      rgb_out   <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

/* ship/draw_rect.sv */
// pipeline stage that paints the solid ship rectangle over the background pixel stream
`timescale 1ns/100ps
`default_nettype none

module draw_rect (
  input  wire         pclk,
  input  wire         rst,
  input  wire  [10:0] hcount_in,
  input  wire  [10:0] vcount_in,
  input  wire         hsync_in,
  input  wire         vsync_in,
  input  wire         blank_in,
  input  wire  [11:0] rgb_in,
  input  wire  [10:0] xpos,
  output logic        hsync_out,
  output logic        vsync_out,
  output logic [11:0] rgb_out
);

  logic        in_cols;
  logic        in_rows;
  logic        in_ship;
  logic [11:0] rgb_nxt;

  // --------------------------------------------------------------------------
  // rectangle hit test
  // --------------------------------------------------------------------------
  // columns xpos .. xpos+rect_width-1
  assign in_cols = (hcount_in >= xpos) && (hcount_in < xpos + game_pkg::rect_width);

  // rows ship_ypos .. ship_ypos+rect_height-1
  assign in_rows = (vcount_in >= game_pkg::ship_ypos) &&
                   (vcount_in < game_pkg::ship_ypos + game_pkg::rect_height);

  assign in_ship = !blank_in && in_cols && in_rows;

  always_comb begin
    if (in_ship) begin
      rgb_nxt = game_pkg::color_ship;
    end else begin
      rgb_nxt = rgb_in;
    end
  end

  // --------------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync_out <= 1'b1;
      vsync_out <= 1'b1;
      rgb_out   <= game_pkg::color_black;
    end else begin
      hsync_out <= hsync_in;
      vsync_out <= vsync_in;
      rgb_out   <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

/* hdl/ship_display_top.sv */
// top level joining the key path, the ship controller and the two-stage raster pipeline
`timescale 1ns/100ps
`default_nettype none

module ship_display_top #(
  parameter logic [20:0] step_period     = game_pkg::step_period_default,
  parameter logic [15:0] debounce_cycles = game_pkg::debounce_default
) (
  input  wire        pclk,
  input  wire        rst,
  input  wire        left_raw,
  input  wire        right_raw,
  output wire        hsync,
  output wire        vsync,
  output wire [11:0] rgb,
  output wire [10:0] ship_xpos
);

  wire        left;
  wire        right;
  wire [10:0] tim_hcount;
  wire [10:0] tim_vcount;
  wire        tim_hsync;
  wire        tim_vsync;
  wire        tim_blank;
  wire [10:0] bg_hcount;
  wire [10:0] bg_vcount;
  wire        bg_hsync;
  wire        bg_vsync;
  wire        bg_blank;
  wire [11:0] bg_rgb;

  // --------------------------------------------------------------------------
  // key path and ship position
  // --------------------------------------------------------------------------
  key_sync #(
    .debounce_cycles(debounce_cycles)
  ) key_sync_i (
    .pclk      (pclk),
    .rst       (rst),
    .left_raw  (left_raw),
    .right_raw (right_raw),
    .left      (left),
    .right     (right)
  );

  position_rect_ctl #(
    .step_period(step_period)
  ) position_rect_ctl_i (
    .pclk     (pclk),
    .rst      (rst),
    .left     (left),
    .right    (right),
    .xpos_out (ship_xpos)
  );

  // --------------------------------------------------------------------------
  // raster pipeline
  // --------------------------------------------------------------------------
  vga_timing vga_timing_i (
    .pclk   (pclk),
    .rst    (rst),
    .hcount (tim_hcount),
    .vcount (tim_vcount),
    .hsync  (tim_hsync),
    .vsync  (tim_vsync),
    .blank  (tim_blank)
  );

  draw_background draw_background_i (
    .pclk       (pclk),
    .rst        (rst),
    .hcount_in  (tim_hcount),
    .vcount_in  (tim_vcount),
    .hsync_in   (tim_hsync),
    .vsync_in   (tim_vsync),
    .blank_in   (tim_blank),
    .hcount_out (bg_hcount),
    .vcount_out (bg_vcount),
    .hsync_out  (bg_hsync),
    .vsync_out  (bg_vsync),
    .blank_out  (bg_blank),
    .rgb_out    (bg_rgb)
  );

  // ship drawn at the live controller position
  draw_rect draw_rect_i (
    .pclk      (pclk),
    .rst       (rst),
    .hcount_in (bg_hcount),
    .vcount_in (bg_vcount),
    .hsync_in  (bg_hsync),
    .vsync_in  (bg_vsync),
    .blank_in  (bg_blank),
    .rgb_in    (bg_rgb),
    .xpos      (ship_xpos),
    .hsync_out (hsync),
    .vsync_out (vsync),
    .rgb_out   (rgb)
  );

endmodule

`default_nettype wire

/* verification/ship_display_sva.sv */
// concurrent assertions on the ship controller and the raster timing, attached with bind
`timescale 1ns/100ps
`default_nettype none

module ship_display_sva #(
  parameter bit ctl_target = 1'b1
) (
  input wire                   pclk,
  input wire                   rst,
  input wire            [10:0] xpos,
  input game_pkg::move_state_t state,
  input wire            [10:0] hcount
);

  // --------------------------------------------------------------------------
  // ship controller checks in the controller instance, raster checks otherwise
  // --------------------------------------------------------------------------
  generate
    if (ctl_target) begin : g_ctl
      xpos_in_field: assert property (@(posedge pclk) disable iff (rst)
        (xpos >= game_pkg::play_x_min) && (xpos <= game_pkg::play_x_max))
        else $error("ship x position outside the playfield");

      // one pixel per step at most
      xpos_single_step: assert property (@(posedge pclk) disable iff (rst)
        (xpos == $past(xpos)) || (xpos == $past(xpos) + 11'd1) ||
        (xpos + 11'd1 == $past(xpos)))
        else $error("ship x position jumped by more than one pixel");

      state_legal: assert property (@(posedge pclk) disable iff (rst)
        state inside {game_pkg::idle, game_pkg::move_left, game_pkg::move_right})
        else $error("controller state outside the enum");
    end else begin : g_timing
      hcount_below_total: assert property (@(posedge pclk) disable iff (rst)
        hcount < game_pkg::h_total)
        else $error("hcount reached the line length");
    end
  endgenerate

endmodule

// each target gets its own group of checks, the unused ports are tied off
bind position_rect_ctl ship_display_sva #(
  .ctl_target (1'b1)
) ctl_sva_i (
  .pclk   (pclk),
  .rst    (rst),
  .xpos   (xpos_out),
  .state  (state),
  .hcount (11'd0)
);

bind vga_timing ship_display_sva #(
  .ctl_target (1'b0)
) timing_sva_i (
  .pclk   (pclk),
  .rst    (rst),
  .xpos   (game_pkg::reset_xpos),
  .state  (game_pkg::idle),
  .hcount (hcount)
);

`default_nettype wire

/* verification/ship_display_tb.sv */
// testbench for ship_display_top, checks key moves against a reference model and a full frame
`timescale 1ns/100ps
`default_nettype none

module ship_display_tb;

  localparam int step_period     = 8;
  localparam int debounce_cycles = 4;

  // package geometry as plain integers for the model arithmetic
  localparam int h_act    = int'(game_pkg::h_active);
  localparam int v_act    = int'(game_pkg::v_active);
  localparam int h_tot    = int'(game_pkg::h_total);
  localparam int v_tot    = int'(game_pkg::v_total);
  localparam int hs_start = int'(game_pkg::h_active) + int'(game_pkg::h_front);
  localparam int hs_end   = hs_start + int'(game_pkg::h_sync);
  localparam int vs_start = int'(game_pkg::v_active) + int'(game_pkg::v_front);
  localparam int vs_end   = vs_start + int'(game_pkg::v_sync);
  localparam int x_min    = int'(game_pkg::play_x_min);
  localparam int x_max    = int'(game_pkg::play_x_max);
  localparam int x_edge   = int'(game_pkg::play_x_edge);
  localparam int rect_w   = int'(game_pkg::rect_width);
  localparam int rect_h   = int'(game_pkg::rect_height);
  localparam int ship_y   = int'(game_pkg::ship_ypos);
  localparam int reset_x  = int'(game_pkg::reset_xpos);
  localparam int frame_pixels = h_tot * v_tot;

  // --------------------------------------------------------------------------
  // stimulus table
  // kind 0 model only, 1 at right edge, 2 at left edge, 3 unchanged,
  // 4 moved left, 5 at reset position
  // --------------------------------------------------------------------------
  localparam int n_rows = 17;
  localparam int row_left [n_rows]   = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0};
  localparam int row_right [n_rows]  = '{0, 1, 0, 1, 0, 0, 0, 1, 0, 1, 0, 0, 1, 1, 0, 1, 0};
  localparam int row_hold [n_rows]   = '{20, 400, 20, 7600, 20, 7600, 20, 300, 20, 200, 20,
                                         80, 80, 12, 20, 40, 20};
  localparam int row_bounce [n_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0};
  localparam int row_kind [n_rows]   = '{5, 0, 0, 1, 0, 2, 0, 0, 0, 4, 0, 3, 3, 0, 0, 0, 0};
  string row_name [n_rows] = '{"idle_after_reset", "right_short", "idle", "right_to_edge",
                               "idle", "left_to_edge", "idle", "right_away", "idle",
                               "both_keys", "idle", "bounce_left", "bounce_right",
                               "short_press", "idle", "next_press", "idle"};

  logic        pclk;
  logic        rst;
  logic        left_raw;
  logic        right_raw;
  wire         hsync;
  wire         vsync;
  wire  [11:0] rgb;
  wire  [10:0] ship_xpos;

  int errors       = 0;
  int raster_errs  = 0;
  int tests        = 0;
  int failed_tests = 0;

  // reference model state
  logic [1:0]            m_sync_a;
  logic [1:0]            m_sync_b;
  logic [1:0]            m_key;
  int                    m_run [2];
  game_pkg::move_state_t m_state;
  int                    m_cnt;
  int                    m_xpos;
  int                    m_pix;
  logic [11:0]           exp_rgb;
  logic                  exp_hsync;
  logic                  exp_vsync;
  logic                  started    = 1'b0;
  logic                  frame_done = 1'b0;

  ship_display_top #(
    .step_period     (21'd8),
    .debounce_cycles (16'd4)
  ) ship_display_top_i (
    .pclk      (pclk),
    .rst       (rst),
    .left_raw  (left_raw),
    .right_raw (right_raw),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb       (rgb),
    .ship_xpos (ship_xpos)
  );

  initial begin : clock
    pclk = 1'b0;
    forever #5 pclk = ~pclk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int bad);
    tests = tests + 1;
    if (bad != 0) begin
      failed_tests = failed_tests + 1;
      $display("test %0d %s: FAILED with %0d errors", tests, name, bad);
    end else begin
      $display("test %0d %s: ok, ship_xpos %0d", tests, name, ship_xpos);
    end
  endtask

  function automatic int total_hold();
    int sum;
    sum = 0;
    for (int r = 0; r < n_rows; r++) begin
      sum = sum + row_hold[r];
    end
    return sum;
  endfunction

  // expected color of one raster pixel for a given ship x
  function automatic logic [11:0] pixel_color(input int h, input int v, input int x);
    if (h >= h_act || v >= v_act) begin
      return game_pkg::color_black;
    end
    if (h >= x && h < x + rect_w && v >= ship_y && v < ship_y + rect_h) begin
      return game_pkg::color_ship;
    end
    if (h < x_min || h >= x_edge) begin
      return game_pkg::color_border;
    end
    return game_pkg::color_field;
  endfunction

  // drive one key level pair for n cycles, 1 ns after each rising edge
  task automatic hold_keys(input logic l, input logic r, input int n);
    repeat (n) begin
      left_raw  = l;
      right_raw = r;
      @(posedge pclk);
      #1;
    end
  endtask

  // short random pulses, always shorter than the debounce time
  task automatic bounce_keys(input logic l, input logic r, input int n);
    int done;
    int len;
    done = 0;
    while (done < n) begin
      len = 1 + int'($urandom % (debounce_cycles - 1));
      if (len > n - done) len = n - done;
      hold_keys(l, r, len);
      done = done + len;
      len = 1 + int'($urandom % 3);
      if (len > n - done) len = n - done;
      hold_keys(1'b0, 1'b0, len);
      done = done + len;
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model, one step per rising edge
  // --------------------------------------------------------------------------
  always @(posedge pclk) begin : model
    int q;
    int hq;
    int vq;
    logic [1:0] raw_now;
    raw_now = {right_raw, left_raw};
    if (rst) begin
      m_sync_a  = 2'b00;
      m_sync_b  = 2'b00;
      m_key     = 2'b00;
      m_run[0]  = 0;
      m_run[1]  = 0;
      m_state   = game_pkg::idle;
      m_cnt     = 0;
      m_xpos    = reset_x;
      m_pix     = 0;
      exp_rgb   = game_pkg::color_black;
      exp_hsync = 1'b1;
      exp_vsync = 1'b1;
    end else begin
      // rgb two stages behind the raster, ship at the x held before this edge
      m_pix = m_pix + 1;
      if (m_pix >= 2) begin
        q  = m_pix - 2;
        hq = q % h_tot;
        vq = (q / h_tot) % v_tot;
        exp_rgb   = pixel_color(hq, vq, m_xpos);
        exp_hsync = !(hq >= hs_start && hq < hs_end);
        exp_vsync = !(vq >= vs_start && vq < vs_end);
        if (q == frame_pixels - 1) frame_done = 1'b1;
      end
      // step counter holds in idle
      if (m_state != game_pkg::idle) begin
        if (m_cnt == step_period) begin
          m_cnt = 0;
          if (m_state == game_pkg::move_left && m_xpos > x_min) m_xpos = m_xpos - 1;
          if (m_state == game_pkg::move_right && m_xpos < x_max) m_xpos = m_xpos + 1;
        end else begin
          m_cnt = m_cnt + 1;
        end
      end
      // state follows the debounced keys, left first
      case (m_state)
        game_pkg::move_left: begin
          if (!m_key[0]) m_state = game_pkg::idle;
        end
        game_pkg::move_right: begin
          if (!m_key[1]) m_state = game_pkg::idle;
        end
        default: begin
          if (m_key[0]) begin
            m_state = game_pkg::move_left;
          end else if (m_key[1]) begin
            m_state = game_pkg::move_right;
          end
        end
      endcase
      // debounce, then the two synchronizer stages
      for (int k = 0; k < 2; k++) begin
        if (m_sync_b[k] == m_key[k]) begin
          m_run[k] = 0;
        end else if (m_run[k] == debounce_cycles) begin
          m_key[k] = m_sync_b[k];
          m_run[k] = 0;
        end else begin
          m_run[k] = m_run[k] + 1;
        end
        m_sync_b[k] = m_sync_a[k];
        m_sync_a[k] = raw_now[k];
      end
    end
    started = 1'b1;
  end

  // outputs are compared at the falling edge, away from the register updates
  always @(negedge pclk) begin : compare_outputs
    int errs_before;
    if (started) begin
      check_value("ship_xpos", 32'(ship_xpos), m_xpos);
      errs_before = errors;
      check_value("rgb", 32'(rgb), 32'(exp_rgb));
      check_value("hsync", 32'(hsync), 32'(exp_hsync));
      check_value("vsync", 32'(vsync), 32'(exp_vsync));
      raster_errs = raster_errs + errors - errs_before;
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    int r;
    int start_x;
    int errs_before;
    void'($urandom(32'h33def030));
    rst       = 1'b1;
    left_raw  = 1'b0;
    right_raw = 1'b0;
    repeat (2) @(posedge pclk);
    #1;
    rst = 1'b0;

    errs_before = errors;
    check_value("ship_xpos", 32'(ship_xpos), reset_x);
    check_value("hsync", 32'(hsync), 32'd1);
    check_value("vsync", 32'(vsync), 32'd1);
    report_test("reset_values", errors - errs_before);

    for (r = 0; r < n_rows; r++) begin
      start_x     = m_xpos;
      errs_before = errors;
      if (row_bounce[r] != 0) begin
        bounce_keys(row_left[r] != 0, row_right[r] != 0, row_hold[r]);
      end else begin
        hold_keys(row_left[r] != 0, row_right[r] != 0, row_hold[r]);
      end
      check_value("ship_xpos", 32'(ship_xpos), m_xpos);
      case (row_kind[r])
        1: check_value("ship_xpos", 32'(ship_xpos), x_max);
        2: check_value("ship_xpos", 32'(ship_xpos), x_min);
        3: check_value("ship_xpos", 32'(ship_xpos), start_x);
        4: check_value("moved_left", (32'(ship_xpos) < start_x) ? 32'd1 : 32'd0, 32'd1);
        5: check_value("ship_xpos", 32'(ship_xpos), reset_x);
        default: ;
      endcase
      report_test(row_name[r], errors - errs_before);
    end

    // the raster checker has to see every pixel of the first frame
    wait (frame_done);
    @(negedge pclk);
    #1;
    report_test("raster_frame", raster_errs);
    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    longint limit;
    limit = longint'(total_hold()) + longint'(frame_pixels) + 20000;
    #(limit * 10);
    $display("timeout: no result after %0d clock cycles", limit);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/game_pkg.sv
hdl/key_sync.sv
ship/position_rect_ctl.sv
hdl/vga_timing.sv
hdl/draw_background.sv
ship/draw_rect.sv
hdl/ship_display_top.sv
verification/ship_display_sva.sv
verification/ship_display_tb.sv

/* Makefile */
# Verilator build and run of the ship display testbench

TOP = ship_display_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
